/* hdl/nn_controller.sv */
`timescale 1ns/10ps

module nn_controller (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   enable,
    input  logic                   stage_ovf,
    input  logic                   stage_zero,
    output nn_ctrl_pkg::nn_state_t state,
    output logic [3:0]             rom_addr1,
    output logic [3:0]             rom_addr2,
    output logic                   rf_write,
    output logic [3:0]             rf_waddr1,
    output logic [3:0]             rf_waddr2,
    output logic                   busy,
    output logic                   total_ovf,
    output logic                   total_zero,
    output logic [2:0]             ovf_fsm_stage,
    output logic [2:0]             zero_fsm_stage
);
    import nn_data_pkg::*;
    import nn_ctrl_pkg::*;

    nn_state_t                    next_state;
    logic [3:0]                   load_cnt;    // 0 to LOAD_LAST
    logic                         out_step;
    logic [2:0]                   wr_pair;     // Pair requested one cycle earlier
    logic [$clog2(NN_REGS)-1:0]   req_base;    // Even word of requested pair
    logic                         processing;

    assign processing = state inside {PRE_PROC, INPUT_LAYER, OUT_LAYER, POST_PROC};
    assign busy       = processing || state == LOAD;

    // Load addressing, ROM read lands one cycle later
    assign req_base  = {load_cnt[2:0], 1'b0};
    assign rom_addr1 = req_base;
    assign rom_addr2 = req_base | 4'd1;
    assign wr_pair   = load_cnt[2:0] - 3'd1;  // Count 8 wraps to pair 7
    assign rf_write  = state == LOAD && load_cnt != '0;
    assign rf_waddr1 = {wr_pair, 1'b0};
    assign rf_waddr2 = {wr_pair, 1'b1};

    always_comb begin
        next_state = state;
        case (state)
            DEACTIVATED: if (enable) next_state = LOAD;
            LOAD:        if (load_cnt == LOAD_LAST) next_state = IDLE;
            IDLE:        if (enable) next_state = PRE_PROC;
            PRE_PROC:    next_state = INPUT_LAYER;
            INPUT_LAYER: next_state = OUT_LAYER;
            OUT_LAYER:   if (out_step == 1'(OUT_STEPS - 1)) next_state = POST_PROC;
            POST_PROC:   next_state = IDLE;
            default:     next_state = IDLE;
        endcase
        if (processing && stage_ovf) begin
            next_state = IDLE;  // Overflow aborts the run
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= DEACTIVATED;
            load_cnt <= '0;
            out_step <= 1'b0;
        end else begin
            state    <= next_state;
            load_cnt <= (state == LOAD) ? load_cnt + 4'd1 : '0;
            out_step <= (state == OUT_LAYER) ? ~out_step : 1'b0;
        end
    end

    // Sticky flags, first raising stage kept
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            total_ovf      <= 1'b0;
            total_zero     <= 1'b0;
            ovf_fsm_stage  <= STAGE_NONE;
            zero_fsm_stage <= STAGE_NONE;
        end else if (state == IDLE && enable) begin  // Start edge clears
            total_ovf      <= 1'b0;
            total_zero     <= 1'b0;
            ovf_fsm_stage  <= STAGE_NONE;
            zero_fsm_stage <= STAGE_NONE;
        end else if (processing) begin
            if (stage_ovf) begin
                total_ovf <= 1'b1;
                if (!total_ovf) ovf_fsm_stage <= state;
            end
            if (stage_zero) begin
                total_zero <= 1'b1;
                if (!total_zero) zero_fsm_stage <= state;
            end
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!resetn)
        state != 3'd7);

    a_write_in_load: assert property (@(posedge clk) disable iff (!resetn)
        rf_write |-> state == LOAD);

endmodule

/* hdl/nn_ctrl_pkg.sv */
package nn_ctrl_pkg;

    // Moore states, value doubles as the reported stage code
    typedef enum logic [2:0] {
        DEACTIVATED = 3'd0,  // After reset, weights not loaded
        LOAD        = 3'd1,  // ROM to register file copy
        IDLE        = 3'd2,  // Wait for enable
        PRE_PROC    = 3'd3,  // Input right shifts
        INPUT_LAYER = 3'd4,  // Two parallel MACs
        OUT_LAYER   = 3'd5,  // Two serial MACs
        POST_PROC   = 3'd6   // Output left shift
    } nn_state_t;

    localparam logic [2:0] STAGE_NONE = 3'd7;  // No stage recorded

    // Load runs counter values 0 to LOAD_LAST
    localparam logic [3:0] LOAD_LAST = 4'd8;

    // Serial steps in the output layer
    localparam int OUT_STEPS = 2;

endpackage

/* hdl/nn_data_pkg.sv */
package nn_data_pkg;

    localparam int NN_WIDTH = 32;  // Datapath word
    localparam int NN_REGS  = 16;  // Register file depth

    // Shift entry view, amount sits in the low bits
    typedef struct packed {
        logic [NN_WIDTH-6:0] unused;
        logic [4:0]          amount;
    } nn_shift_t;

    // One register-file word, weight/bias or shift amount
    typedef union packed {
        logic signed [NN_WIDTH-1:0] value;
        nn_shift_t                  shift;
    } nn_word_u;

    // Register-file address map
    localparam logic [3:0] RF_SHIFT1 = 4'd2;   // Input 1 pre-shift
    localparam logic [3:0] RF_SHIFT2 = 4'd3;   // Input 2 pre-shift
    localparam logic [3:0] RF_W1     = 4'd4;
    localparam logic [3:0] RF_B1     = 4'd5;
    localparam logic [3:0] RF_W2     = 4'd6;
    localparam logic [3:0] RF_B2     = 4'd7;
    localparam logic [3:0] RF_W3     = 4'd8;
    localparam logic [3:0] RF_W4     = 4'd9;
    localparam logic [3:0] RF_B3     = 4'd10;
    localparam logic [3:0] RF_SHIFT3 = 4'd11;  // Post-shift, left

    // Saturation value on overflow
    localparam logic signed [NN_WIDTH-1:0] NN_SAT_MAX = {1'b0, {(NN_WIDTH-1){1'b1}}};

endpackage

/* hdl/nn_datapath.sv */
`timescale 1ns/10ps

module nn_datapath (
    input  logic                                    clk,
    input  logic                                    resetn,
    input  nn_ctrl_pkg::nn_state_t                  state,
    input  logic signed [nn_data_pkg::NN_WIDTH-1:0] input_1,
    input  logic signed [nn_data_pkg::NN_WIDTH-1:0] input_2,
    output logic [3:0]                              rf_raddr1,
    output logic [3:0]                              rf_raddr2,
    output logic [3:0]                              rf_raddr3,
    output logic [3:0]                              rf_raddr4,
    input  nn_data_pkg::nn_word_u                   rf_rdata1,
    input  nn_data_pkg::nn_word_u                   rf_rdata2,
    input  nn_data_pkg::nn_word_u                   rf_rdata3,
    input  nn_data_pkg::nn_word_u                   rf_rdata4,
    output logic                                    stage_ovf,
    output logic                                    stage_zero,
    output logic signed [nn_data_pkg::NN_WIDTH-1:0] final_output
);
    import nn_data_pkg::*;
    import nn_ctrl_pkg::*;

    logic signed [NN_WIDTH-1:0] inter_1, inter_2, inter_3, inter_4, inter_5;
    logic signed [NN_WIDTH-1:0] temp_result;  // First output-layer step
    logic                       step;         // Output-layer step, local copy

    // Unit operands and results
    logic signed [NN_WIDTH-1:0] alu1_val, alu2_val, alu1_res, alu2_res;
    logic [4:0]                 alu1_amt, alu2_amt;
    logic                       alu1_ovf, alu2_ovf, alu1_zero, alu2_zero;
    logic signed [NN_WIDTH-1:0] mac1_a, mac1_b, mac1_c, mac1_res;
    logic signed [NN_WIDTH-1:0] mac2_a, mac2_b, mac2_c, mac2_res;
    logic mac1_ovf_mul, mac1_ovf_add, mac1_zero_mul, mac1_zero_add;
    logic mac2_ovf_mul, mac2_ovf_add, mac2_zero_mul, mac2_zero_add;

    nn_shift_alu u_alu_1 (.value(alu1_val), .amount(alu1_amt), .left(state == POST_PROC),
                          .result(alu1_res), .ovf(alu1_ovf), .zero(alu1_zero));
    nn_shift_alu u_alu_2 (.value(alu2_val), .amount(alu2_amt), .left(1'b0),
                          .result(alu2_res), .ovf(alu2_ovf), .zero(alu2_zero));

    nn_mac u_mac_1 (.a(mac1_a), .b(mac1_b), .c(mac1_c), .result(mac1_res),
                    .ovf_mul(mac1_ovf_mul), .ovf_add(mac1_ovf_add),
                    .zero_mul(mac1_zero_mul), .zero_add(mac1_zero_add));
    nn_mac u_mac_2 (.a(mac2_a), .b(mac2_b), .c(mac2_c), .result(mac2_res),
                    .ovf_mul(mac2_ovf_mul), .ovf_add(mac2_ovf_add),
                    .zero_mul(mac2_zero_mul), .zero_add(mac2_zero_add));

    // Operand routing per state; flags quiet outside the processing stages
    always_comb begin
        rf_raddr1 = '0;
        rf_raddr2 = '0;
        rf_raddr3 = '0;
        rf_raddr4 = '0;
        alu1_val = input_1;
        alu1_amt = rf_rdata1.shift.amount;
        alu2_val = input_2;
        alu2_amt = rf_rdata2.shift.amount;
        mac1_a = inter_1;
        mac1_b = rf_rdata1.value;
        mac1_c = rf_rdata2.value;
        mac2_a = inter_2;
        mac2_b = rf_rdata3.value;
        mac2_c = rf_rdata4.value;
        stage_ovf  = 1'b0;
        stage_zero = 1'b0;
        case (state)
            PRE_PROC: begin
                rf_raddr1  = RF_SHIFT1;
                rf_raddr2  = RF_SHIFT2;
                stage_ovf  = alu1_ovf | alu2_ovf;
                stage_zero = alu1_zero | alu2_zero;
            end
            INPUT_LAYER: begin  // Both MACs in parallel
                rf_raddr1  = RF_W1;
                rf_raddr2  = RF_B1;
                rf_raddr3  = RF_W2;
                rf_raddr4  = RF_B2;
                stage_ovf  = mac1_ovf_mul | mac1_ovf_add | mac2_ovf_mul | mac2_ovf_add;
                stage_zero = mac1_zero_mul | mac1_zero_add | mac2_zero_mul | mac2_zero_add;
            end
            OUT_LAYER: begin
                if (!step) begin  // inter_3 * w3 + b3
                    rf_raddr1  = RF_W3;
                    rf_raddr3  = RF_B3;
                    mac1_a     = inter_3;
                    mac1_c     = rf_rdata3.value;
                    stage_ovf  = mac1_ovf_mul | mac1_ovf_add;
                    stage_zero = mac1_zero_mul | mac1_zero_add;
                end else begin    // inter_4 * w4 + temp
                    rf_raddr2  = RF_W4;
                    mac2_a     = inter_4;
                    mac2_b     = rf_rdata2.value;
                    mac2_c     = temp_result;
                    stage_ovf  = mac2_ovf_mul | mac2_ovf_add;
                    stage_zero = mac2_zero_mul | mac2_zero_add;
                end
            end
            POST_PROC: begin
                rf_raddr1  = RF_SHIFT3;
                alu1_val   = inter_5;
                stage_ovf  = alu1_ovf;
                stage_zero = alu1_zero;
            end
            default: ;
        endcase
    end

    // Stage results, written only in their own state
    always_ff @(posedge clk) begin
        case (state)
            PRE_PROC: begin
                inter_1 <= alu1_res;
                inter_2 <= alu2_res;
            end
            INPUT_LAYER: begin
                inter_3 <= mac1_res;
                inter_4 <= mac2_res;
            end
            OUT_LAYER: begin
                if (!step) begin
                    temp_result <= mac1_res;
                end else begin
                    inter_5 <= mac2_res;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            step         <= 1'b0;
            final_output <= '0;
        end else begin
            step <= (state == OUT_LAYER) ? ~step : 1'b0;
            if (stage_ovf) begin
                final_output <= NN_SAT_MAX;  // Abort saturates
            end else if (state == POST_PROC) begin
                final_output <= alu1_res;
            end
        end
    end

    a_post_ovf_sat: assert property (@(posedge clk) disable iff (!resetn)
        (state == POST_PROC && stage_ovf) |=> final_output == NN_SAT_MAX);

endmodule

/* hdl/nn_mac.sv */
`timescale 1ns/10ps

module nn_mac (
    input  logic signed [nn_data_pkg::NN_WIDTH-1:0] a,
    input  logic signed [nn_data_pkg::NN_WIDTH-1:0] b,
    input  logic signed [nn_data_pkg::NN_WIDTH-1:0] c,
    output logic signed [nn_data_pkg::NN_WIDTH-1:0] result,
    output logic                                    ovf_mul,
    output logic                                    ovf_add,
    output logic                                    zero_mul,
    output logic                                    zero_add
);
    import nn_data_pkg::*;

    logic signed [2*NN_WIDTH-1:0] product;  // Full precision
    logic signed [NN_WIDTH-1:0]   prod_lo;
    logic signed [NN_WIDTH-1:0]   sum;

    assign product = a * b;
    assign prod_lo = product[NN_WIDTH-1:0];
    assign sum     = prod_lo + c;  // Wraps, flagged below
    assign result  = sum;

    // Product fits only if upper half is sign of low word
    assign ovf_mul = product[2*NN_WIDTH-1:NN_WIDTH-1] != {(NN_WIDTH+1){prod_lo[NN_WIDTH-1]}};

    // Same-sign operands, sum sign flipped
    assign ovf_add = (prod_lo[NN_WIDTH-1] == c[NN_WIDTH-1]) &&
                     (sum[NN_WIDTH-1] != c[NN_WIDTH-1]);

    assign zero_mul = product == '0;
    assign zero_add = sum == '0;

endmodule

/* hdl/nn_regfile.sv */
`timescale 1ns/10ps

module nn_regfile (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  write,
    input  logic [3:0]            raddr1,
    input  logic [3:0]            raddr2,
    input  logic [3:0]            raddr3,
    input  logic [3:0]            raddr4,
    input  logic [3:0]            waddr1,
    input  logic [3:0]            waddr2,
    input  nn_data_pkg::nn_word_u wdata1,
    input  nn_data_pkg::nn_word_u wdata2,
    output nn_data_pkg::nn_word_u rdata1,
    output nn_data_pkg::nn_word_u rdata2,
    output nn_data_pkg::nn_word_u rdata3,
    output nn_data_pkg::nn_word_u rdata4
);
    import nn_data_pkg::*;

    nn_word_u regs [NN_REGS];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < NN_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write) begin
            regs[waddr1] <= wdata1;  // Even word of the pair
            regs[waddr2] <= wdata2;  // Odd word
        end
    end

    // Reads are combinational
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];
    assign rdata3 = regs[raddr3];
    assign rdata4 = regs[raddr4];

    // Controller must never hand both ports the same word
    a_write_addr_differ: assert property (@(posedge clk) disable iff (!resetn)
        write |-> waddr1 != waddr2);

endmodule

/* hdl/nn_shift_alu.sv */
`timescale 1ns/10ps

module nn_shift_alu (
    input  logic signed [nn_data_pkg::NN_WIDTH-1:0] value,
    input  logic [4:0]                              amount,
    input  logic                                    left,    // 0 gives right shift
    output logic signed [nn_data_pkg::NN_WIDTH-1:0] result,
    output logic                                    ovf,
    output logic                                    zero
);
    import nn_data_pkg::*;

    logic signed [2*NN_WIDTH-1:0] wide;     // Sign-extended, shifted left
    logic [NN_WIDTH:0]            top_bits;

    assign wide     = {{NN_WIDTH{value[NN_WIDTH-1]}}, value} <<< amount;
    assign top_bits = wide[2*NN_WIDTH-1:NN_WIDTH-1];  // Shifted-out bits plus new sign

    always_comb begin
        if (left) begin
            result = wide[NN_WIDTH-1:0];
            // Every dropped bit and the new sign must copy the old sign
            ovf    = top_bits != {(NN_WIDTH+1){value[NN_WIDTH-1]}};
        end else begin
            result = value >>> amount;
            ovf    = 1'b0;  // Right shift cannot overflow
        end
    end

    assign zero = result == '0;

endmodule

/* hdl/nn_top.sv */
`timescale 1ns/10ps

module nn_top (
    input  logic                                    clk,
    input  logic                                    resetn,
    input  logic                                    enable,
    input  logic signed [nn_data_pkg::NN_WIDTH-1:0] input_1,
    input  logic signed [nn_data_pkg::NN_WIDTH-1:0] input_2,
    output logic signed [nn_data_pkg::NN_WIDTH-1:0] final_output,
    output logic                                    total_ovf,
    output logic                                    total_zero,
    output logic                                    busy,
    output logic [2:0]                              ovf_fsm_stage,
    output logic [2:0]                              zero_fsm_stage
);
    import nn_data_pkg::*;

    nn_ctrl_pkg::nn_state_t state;
    logic [3:0] rom_addr1, rom_addr2, rf_waddr1, rf_waddr2;
    logic [3:0] rf_raddr1, rf_raddr2, rf_raddr3, rf_raddr4;
    logic       rf_write, stage_ovf, stage_zero;
    nn_word_u   rom_data1, rom_data2;  // ROM straight into register file
    nn_word_u   rf_rdata1, rf_rdata2, rf_rdata3, rf_rdata4;

    nn_controller u_ctrl (
        .clk(clk), .resetn(resetn), .enable(enable),
        .stage_ovf(stage_ovf), .stage_zero(stage_zero), .state(state),
        .rom_addr1(rom_addr1), .rom_addr2(rom_addr2),
        .rf_write(rf_write), .rf_waddr1(rf_waddr1), .rf_waddr2(rf_waddr2),
        .busy(busy), .total_ovf(total_ovf), .total_zero(total_zero),
        .ovf_fsm_stage(ovf_fsm_stage), .zero_fsm_stage(zero_fsm_stage)
    );

    weight_rom u_rom (
        .clk(clk), .addr1(rom_addr1), .addr2(rom_addr2),
        .dout1(rom_data1), .dout2(rom_data2)
    );

    nn_regfile u_rf (
        .clk(clk), .resetn(resetn), .write(rf_write),
        .raddr1(rf_raddr1), .raddr2(rf_raddr2), .raddr3(rf_raddr3), .raddr4(rf_raddr4),
        .waddr1(rf_waddr1), .waddr2(rf_waddr2), .wdata1(rom_data1), .wdata2(rom_data2),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2), .rdata3(rf_rdata3), .rdata4(rf_rdata4)
    );

    nn_datapath u_dp (
        .clk(clk), .resetn(resetn), .state(state),
        .input_1(input_1), .input_2(input_2),
        .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
        .rf_raddr3(rf_raddr3), .rf_raddr4(rf_raddr4),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .rf_rdata3(rf_rdata3), .rf_rdata4(rf_rdata4),
        .stage_ovf(stage_ovf), .stage_zero(stage_zero), .final_output(final_output)
    );

endmodule

/* hdl/weight_rom.sv */
`timescale 1ns/10ps

module weight_rom (
    input  logic        clk,
    input  logic [3:0]  addr1,
    input  logic [3:0]  addr2,
    output logic [31:0] dout1,
    output logic [31:0] dout2
);

    logic [31:0] rom [16];  // Word addressed

    initial begin
        $readmemh("nn_weights.mem", rom);
    end

    // One cycle read latency on both ports
    always_ff @(posedge clk) begin
        dout1 <= rom[addr1];
        dout2 <= rom[addr2];
    end

endmodule

/* nn.f */
+incdir+include
hdl/nn_data_pkg.sv
hdl/nn_ctrl_pkg.sv
hdl/weight_rom.sv
hdl/nn_regfile.sv
hdl/nn_shift_alu.sv
hdl/nn_mac.sv
hdl/nn_datapath.sv
hdl/nn_controller.sv
hdl/nn_top.sv
test/tb_nn.sv

/* nn_weights.mem */
// One 32-bit hex word per line, word address 0 to 15
// 2,3 pre-shifts; 4 to 10 weights and biases; 11 post-shift
00000000
00000000
00000002
00000003
00000003
00000005
FFFFFFFE
00000011
00000007
FFFFFFFB
00000020
00000004
00000000
00000000
00000000
00000000

/* include/nn_ref_model.svh */
`ifndef NN_REF_MODEL_SVH
`define NN_REF_MODEL_SVH

// Local copy of the ROM image, same indexing as the register file
logic [31:0] model_rom [16];

task automatic load_model_weights();
    $readmemh("nn_weights.mem", model_rom);
endtask

// Legal signed 32-bit range
function automatic logic fits_word(input longint v);
    return v >= -(64'sd1 <<< 31) && v < (64'sd1 <<< 31);
endfunction

// a * b + c, wrapped word result with its flags
function automatic logic signed [31:0] mac_model(input logic signed [31:0] a,
                                                 input logic signed [31:0] b,
                                                 input logic signed [31:0] c,
                                                 output logic ovf,
                                                 output logic zero);
    longint             prod;
    logic signed [31:0] low;
    longint             sum;
    prod = longint'(a) * longint'(b);  // Exact product
    low  = prod[31:0];
    sum  = longint'(low) + longint'(c);
    ovf  = !fits_word(prod) || !fits_word(sum);
    zero = prod == 0 || sum[31:0] == 0;
    return sum[31:0];
endfunction

// Arithmetic left shift, overflow when the exact value leaves the word
function automatic logic signed [31:0] shl_model(input logic signed [31:0] v,
                                                 input logic [4:0] amt,
                                                 output logic ovf);
    longint wide;
    wide = longint'(v) <<< amt;
    ovf  = !fits_word(wide);
    return wide[31:0];
endfunction

// Whole run, one loop pass per clocked stage step
task automatic predict_run(input  logic signed [31:0] in1,
                           input  logic signed [31:0] in2,
                           output logic signed [31:0] exp_out,
                           output logic               exp_ovf,
                           output logic               exp_zero,
                           output logic [2:0]         exp_ovf_st,
                           output logic [2:0]         exp_zero_st,
                           output int                 steps);
    logic signed [31:0] i1, i2, i3, i4, i5, tmp, post;
    logic               o1, o2, z1, z2, s_ovf, s_zero;
    nn_state_t          stage;
    exp_ovf     = 1'b0;
    exp_zero    = 1'b0;
    exp_ovf_st  = STAGE_NONE;
    exp_zero_st = STAGE_NONE;
    post        = '0;
    steps       = 0;
    for (int k = 0; k < 5; k++) begin
        steps = k + 1;
        case (k)
            0: begin  // Right shifts never overflow
                stage  = PRE_PROC;
                i1     = in1 >>> model_rom[RF_SHIFT1][4:0];
                i2     = in2 >>> model_rom[RF_SHIFT2][4:0];
                s_ovf  = 1'b0;
                s_zero = i1 == 0 || i2 == 0;
            end
            1: begin
                stage  = INPUT_LAYER;
                i3     = mac_model(i1, model_rom[RF_W1], model_rom[RF_B1], o1, z1);
                i4     = mac_model(i2, model_rom[RF_W2], model_rom[RF_B2], o2, z2);
                s_ovf  = o1 | o2;
                s_zero = z1 | z2;
            end
            2: begin
                stage = OUT_LAYER;
                tmp   = mac_model(i3, model_rom[RF_W3], model_rom[RF_B3], s_ovf, s_zero);
            end
            3: begin  // Second serial step adds the first
                stage = OUT_LAYER;
                i5    = mac_model(i4, model_rom[RF_W4], tmp, s_ovf, s_zero);
            end
            default: begin
                stage  = POST_PROC;
                post   = shl_model(i5, model_rom[RF_SHIFT3][4:0], s_ovf);
                s_zero = post == 0;
            end
        endcase
        if (s_zero && !exp_zero) begin
            exp_zero    = 1'b1;
            exp_zero_st = stage;
        end
        if (s_ovf) begin  // Abort, back to idle
            exp_ovf    = 1'b1;
            exp_ovf_st = stage;
            break;
        end
    end
    exp_out = exp_ovf ? NN_SAT_MAX : post;
endtask

`endif

/* test/tb_nn.sv */
`timescale 1ns/10ps

module tb_nn;
    import nn_data_pkg::*;
    import nn_ctrl_pkg::*;

    localparam int WAIT_LIMIT = 50;  // Edges per busy wait

    logic                       clk;
    logic                       resetn;
    logic                       enable;
    logic signed [NN_WIDTH-1:0] input_1;
    logic signed [NN_WIDTH-1:0] input_2;
    logic signed [NN_WIDTH-1:0] final_output;
    logic                       total_ovf;
    logic                       total_zero;
    logic                       busy;
    logic [2:0]                 ovf_fsm_stage;
    logic [2:0]                 zero_fsm_stage;

    `include "nn_ref_model.svh"

    nn_top UUT (
        .clk(clk), .resetn(resetn), .enable(enable),
        .input_1(input_1), .input_2(input_2), .final_output(final_output),
        .total_ovf(total_ovf), .total_zero(total_zero), .busy(busy),
        .ovf_fsm_stage(ovf_fsm_stage), .zero_fsm_stage(zero_fsm_stage)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    task automatic fail_and_stop();
        $display("STATUS: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error %s: %s expected %0h, actual %0h", test, what, expected, actual);
            fail_and_stop();
        end
    endtask

    task automatic check_true(input bit cond, input string msg);
        assert (cond) else begin
            $display("%s", msg);
            fail_and_stop();
        end
    endtask

    // Counts edges from the current one until busy drops
    task automatic wait_not_busy(input string test, output int edges);
        edges = 0;
        while (busy && edges < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            edges++;
        end
        if (busy) begin
            $display("Timeout in %s: busy still high after %0d cycles", test, WAIT_LIMIT);
            fail_and_stop();
        end
    endtask

    // Returns 2 ns after the start edge
    task automatic start_run(input logic signed [31:0] in1, input logic signed [31:0] in2);
        input_1 = in1;
        input_2 = in2;  // Held until the next run
        enable  = 1'b1;
        @(posedge clk);
        #2;
        enable  = 1'b0;
    endtask

    task automatic run_and_check(input string test, input logic signed [31:0] in1,
                                 input logic signed [31:0] in2, input bit poke_enable);
        logic signed [31:0] exp_out;
        logic               exp_ovf;
        logic               exp_zero;
        logic [2:0]         exp_ovf_st;
        logic [2:0]         exp_zero_st;
        int                 steps;
        int                 edges;
        int                 early;
        predict_run(in1, in2, exp_out, exp_ovf, exp_zero, exp_ovf_st, exp_zero_st, steps);
        early = 0;
        check_true(!busy, {test, ": DUT busy before the start"});
        start_run(in1, in2);
        check_true(busy, {test, ": busy did not rise at the start edge"});
        // Flags cleared by the start edge itself
        check_value(test, "total_ovf at start", 0, total_ovf);
        check_value(test, "total_zero at start", 0, total_zero);
        check_value(test, "ovf_fsm_stage at start", STAGE_NONE, ovf_fsm_stage);
        check_value(test, "zero_fsm_stage at start", STAGE_NONE, zero_fsm_stage);
        if (poke_enable) begin  // Stray pulse seen in INPUT_LAYER
            @(posedge clk);
            #2;
            enable = 1'b1;
            @(posedge clk);
            #2;
            enable = 1'b0;
            early  = 2;
        end
        wait_not_busy(test, edges);
        check_value(test, "run length", steps, edges + early);
        check_value(test, "final_output", exp_out, final_output);
        check_value(test, "total_ovf", exp_ovf, total_ovf);
        check_value(test, "total_zero", exp_zero, total_zero);
        check_value(test, "ovf_fsm_stage", exp_ovf_st, ovf_fsm_stage);
        check_value(test, "zero_fsm_stage", exp_zero_st, zero_fsm_stage);
    endtask

    function automatic int small_value();
        return int'($urandom_range(65535)) - 32768;
    endfunction

    // Sign-extended value of random bit width
    function automatic int ranged_value();
        int w;
        int v;
        w = $urandom_range(32, 1);
        v = $urandom;
        return (v <<< (32 - w)) >>> (32 - w);
    endfunction

    initial begin
        int edges;
        int ovf_runs;
        resetn   = 1'b0;
        enable   = 1'b0;
        input_1  = '0;
        input_2  = '0;
        ovf_runs = 0;
        void'($urandom(94698));
        load_model_weights();
        repeat (10) @(posedge clk);
        #2;
        resetn = 1'b1;

        check_value("reset", "final_output", 0, final_output);
        check_value("reset", "total_ovf", 0, total_ovf);
        check_value("reset", "total_zero", 0, total_zero);
        check_value("reset", "ovf_fsm_stage", STAGE_NONE, ovf_fsm_stage);
        check_value("reset", "zero_fsm_stage", STAGE_NONE, zero_fsm_stage);
        check_true(!busy, "busy is high after reset");

        // Weight load takes 9 cycles in LOAD
        enable = 1'b1;
        @(posedge clk);
        #2;
        enable = 1'b0;
        check_true(busy, "busy did not rise for the weight load");
        wait_not_busy("load", edges);
        check_value("load", "load cycles", 9, edges);

        run_and_check("zero_inputs", 0, 0, 1'b0);
        check_value("zero_inputs", "total_zero", 1, total_zero);
        check_value("zero_inputs", "zero_fsm_stage", PRE_PROC, zero_fsm_stage);

        repeat (200) begin
            run_and_check("normal", small_value(), small_value(), 1'b0);
            check_value("normal", "total_ovf", 0, total_ovf);
        end

        repeat (200) begin
            run_and_check("overflow", ranged_value(), ranged_value(), 1'b0);
            if (total_ovf) ovf_runs++;
        end
        check_true(ovf_runs > 0, "random full-range runs produced no overflow");

        // Overflow left behind for the next run to clear
        run_and_check("clear_setup", 32'h7fff_ffff, 0, 1'b0);
        check_value("clear_setup", "total_ovf", 1, total_ovf);
        run_and_check("clear", small_value(), small_value(), 1'b0);
        check_value("clear", "total_ovf", 0, total_ovf);
        check_value("clear", "ovf_fsm_stage", STAGE_NONE, ovf_fsm_stage);

        repeat (20) begin
            run_and_check("busy_enable", small_value(), small_value(), 1'b1);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule
